/* sources.f */
src/rv_slice_pkg.sv
src/rvc_expander.sv
src/instr_decoder.sv
src/id_stage.sv
src/alu_execute.sv
src/result_commit.sv
src/rv_slice_top.sv
verification/tb_rv_slice.sv

/* verification/tb_rv_slice.sv */
/*
 * testbench for the RV32 pipeline slice
 * random and directed streams checked against a register model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_slice;

    // what one sent instruction is expected to do
    typedef struct packed {
        logic [31:0]           pc;
        logic [31:0]           instr;
        logic                  fault;
        rv_slice_pkg::alu_op_e op;
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [31:0]           imm;
        logic                  use_imm;   // operand b is imm
        logic                  illegal;
    } sent_t;

    logic                       clk_i;
    logic                       rst_ni;
    logic                       flush_i;
    logic                       fetch_valid_i;
    rv_slice_pkg::fetch_entry_t fetch_entry_i;
    logic                       fetch_ready_o;
    logic                       commit_stall_i;
    logic                       commit_valid_o;
    rv_slice_pkg::commit_t      commit_o;

    sent_t       cur;               // entry offered on the fetch port
    sent_t       sent_q[$];         // accepted, not yet committed
    logic [31:0] model_regs [32];
    logic [31:0] next_pc;
    int unsigned errors;
    int unsigned commits;
    string       test_name;
    bit          rand_mode;         // random stall and fetch gaps
    bit          rdy;
    int unsigned pending;
    int unsigned base;

    rv_slice_top #(.ENABLE_RVC(1'b1)) dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // --------------------
    // instruction builders
    // --------------------
    function automatic sent_t i_type(input logic [2:0] f3, input rv_slice_pkg::alu_op_e op,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] imm);
        sent_t s;
        s         = '0;
        s.pc      = next_pc;
        s.instr   = {imm, rs1, f3, rd, 7'b0010011};
        s.op      = op;
        s.rd      = rd;
        s.rs1     = rs1;
        s.imm     = {{20{imm[11]}}, imm};
        s.use_imm = 1'b1;
        next_pc   = next_pc + 32'd4;
        return s;
    endfunction

    function automatic sent_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input rv_slice_pkg::alu_op_e op, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2);
        sent_t s;
        s       = '0;
        s.pc    = next_pc;
        s.instr = {f7, rs2, rs1, f3, rd, 7'b0110011};
        s.op    = op;
        s.rd    = rd;
        s.rs1   = rs1;
        s.rs2   = rs2;
        next_pc = next_pc + 32'd4;
        return s;
    endfunction

    function automatic sent_t make_arith();
        sent_t       s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        rd  = 5'($urandom % 8);   // few registers, so many back-to-back dependencies
        rs1 = 5'($urandom % 8);
        rs2 = 5'($urandom % 8);
        imm = 12'($urandom);
        case ($urandom % 12)
            0:  s = i_type(3'b000, rv_slice_pkg::OP_ADD, rd, rs1, imm);
            1:  s = i_type(3'b100, rv_slice_pkg::OP_XOR, rd, rs1, imm);
            2:  s = i_type(3'b110, rv_slice_pkg::OP_OR, rd, rs1, imm);
            3:  s = i_type(3'b111, rv_slice_pkg::OP_AND, rd, rs1, imm);
            4:  s = r_type(7'h00, 3'b000, rv_slice_pkg::OP_ADD, rd, rs1, rs2);
            5:  s = r_type(7'h20, 3'b000, rv_slice_pkg::OP_SUB, rd, rs1, rs2);
            6:  s = r_type(7'h00, 3'b100, rv_slice_pkg::OP_XOR, rd, rs1, rs2);
            7:  s = r_type(7'h00, 3'b110, rv_slice_pkg::OP_OR, rd, rs1, rs2);
            8:  s = r_type(7'h00, 3'b111, rv_slice_pkg::OP_AND, rd, rs1, rs2);
            9:  s = r_type(7'h00, 3'b001, rv_slice_pkg::OP_SLL, rd, rs1, rs2);
            10: s = r_type(7'h00, 3'b101, rv_slice_pkg::OP_SRL, rd, rs1, rs2);
            default: begin // lui, upper 20 bits random
                s       = i_type(3'b000, rv_slice_pkg::OP_LUI, rd, 5'd0, 12'd0);
                s.imm   = {20'($urandom), 12'b0};
                s.instr = {s.imm[31:12], rd, 7'b0110111};
            end
        endcase
        return s;
    endfunction

    function automatic sent_t make_rvc();
        sent_t      s;
        logic [4:0] rd;
        logic [4:0] rs2;
        logic [5:0] imm;
        rd  = 5'($urandom % 8);
        rs2 = 5'(1 + $urandom % 7);   // rs2 of zero is a jump encoding
        imm = 6'($urandom);
        case ($urandom % 5)
            0: begin // c.li
                s       = i_type(3'b000, rv_slice_pkg::OP_ADD, rd, 5'd0, {{6{imm[5]}}, imm});
                s.instr = {16'h0, 3'b010, imm[5], rd, imm[4:0], 2'b01};
            end
            1: begin // c.addi
                s       = i_type(3'b000, rv_slice_pkg::OP_ADD, rd, rd, {{6{imm[5]}}, imm});
                s.instr = {16'h0, 3'b000, imm[5], rd, imm[4:0], 2'b01};
            end
            2: begin // c.mv
                s       = r_type(7'h00, 3'b000, rv_slice_pkg::OP_ADD, rd, 5'd0, rs2);
                s.instr = {16'h0, 3'b100, 1'b0, rd, rs2, 2'b10};
            end
            3: begin // c.add
                s       = r_type(7'h00, 3'b000, rv_slice_pkg::OP_ADD, rd, rd, rs2);
                s.instr = {16'h0, 3'b100, 1'b1, rd, rs2, 2'b10};
            end
            default: begin // c.lw is not supported
                s         = r_type(7'h00, 3'b000, rv_slice_pkg::OP_ADD, 5'd0, 5'd0, 5'd0);
                s.instr   = {16'h0, 3'b010, 11'($urandom), 2'b00};
                s.illegal = 1'b1;
            end
        endcase
        next_pc = next_pc - 32'd2;   // two bytes long
        return s;
    endfunction

    function automatic sent_t make_bad();
        sent_t s;
        if ($urandom % 2) begin
            s         = r_type(7'h00, 3'b000, rv_slice_pkg::OP_ADD, 5'd0, 5'd0, 5'd0);
            s.instr   = {25'($urandom), 7'b0000011}; // load opcode
            s.illegal = 1'b1;
        end else begin
            s       = make_arith();
            s.fault = 1'b1;                          // legal word, bad fetch
        end
        return s;
    endfunction

    // --------------------
    // checking
    // --------------------
    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            errors++;
            $display("ERROR %s %s: expected %h actual %h", test_name, field, expected, actual);
        end
    endtask

    task automatic check_commit(input sent_t s, input rv_slice_pkg::commit_t c);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        live;   // executes and names a real destination
        a = model_regs[s.rs1];
        b = s.use_imm ? s.imm : model_regs[s.rs2];
        case (s.op)
            rv_slice_pkg::OP_ADD: res = a + b;
            rv_slice_pkg::OP_SUB: res = a - b;
            rv_slice_pkg::OP_XOR: res = a ^ b;
            rv_slice_pkg::OP_OR:  res = a | b;
            rv_slice_pkg::OP_AND: res = a & b;
            rv_slice_pkg::OP_SLL: res = a << b[4:0];
            rv_slice_pkg::OP_SRL: res = a >> b[4:0];
            default:              res = b;   // lui
        endcase
        live = !s.illegal && !s.fault && (s.rd != 5'd0);
        check_value("pc", s.pc, c.pc);
        check_value("illegal", 32'(s.illegal), 32'(c.illegal));
        check_value("fault", 32'(s.fault), 32'(c.fault));
        check_value("we", 32'(live), 32'(c.we));
        check_value("rd", (s.illegal || s.fault) ? 32'd0 : 32'(s.rd), 32'(c.rd));
        if (!s.illegal && !s.fault) check_value("data", res, c.data);
        if (live) model_regs[s.rd] = res;    // x0 is never written
    endtask

    // accept and commit monitor
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (fetch_valid_i && fetch_ready_o) sent_q.push_back(cur);
            if (commit_valid_o && !commit_stall_i) begin
                commits++;
                if (sent_q.size() == 0) begin
                    errors++;
                    $display("commit of pc %h with no instruction outstanding", commit_o.pc);
                end else begin
                    check_commit(sent_q.pop_front(), commit_o);
                end
            end
        end
    end

    a_flush_closes : assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> !fetch_ready_o) else begin
        errors++;
        $display("fetch_ready_o was high during a flush");
    end

    // accept at N, no stall at N+1, strobe seen at N+2
    a_two_cycles : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fetch_valid_i && fetch_ready_o) ##1 !commit_stall_i |=> commit_valid_o) else begin
        errors++;
        $display("commit did not follow an accept by two cycles");
    end

    a_stall_holds : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (commit_valid_o && commit_stall_i) |=> (commit_valid_o && $stable(commit_o))) else begin
        errors++;
        $display("stalled commit changed or vanished");
    end

    // --------------------
    // drivers
    // --------------------
    task automatic abort_run(input string reason);
        $display("timeout: %s", reason);
        $display("errors: %0d, commits: %0d", errors, commits);
        $display(">>> FAIL");
        $finish;
    endtask

    // one clock, then inputs may change 10 ns later
    task automatic next_cycle(output bit ready);
        @(posedge clk_i);
        ready = fetch_ready_o;
        #10;
        if (rand_mode) commit_stall_i = ($urandom % 4 == 0);
    endtask

    task automatic offer(input sent_t s);
        cur                       = s;
        fetch_entry_i.address     = s.pc;
        fetch_entry_i.instruction = s.instr;
        fetch_entry_i.fault       = s.fault;
    endtask

    task automatic send(input sent_t s);
        bit          ready;
        int unsigned waited;
        offer(s);
        fetch_valid_i = 1'b1;
        ready         = 1'b0;
        waited        = 0;
        while (!ready) begin
            if (waited >= 64) begin
                abort_run("fetch handshake never completed");
            end else begin
                next_cycle(ready);   // valid held high, so ready means taken
                waited++;
            end
        end
        fetch_valid_i = 1'b0;
        if (rand_mode && ($urandom % 3 == 0)) next_cycle(ready); // idle gap
    endtask

    task automatic drain();
        bit          ready;
        int unsigned waited;
        waited = 0;
        while (sent_q.size() != 0) begin
            if (waited >= 64) begin
                abort_run("pipeline did not drain");
            end else begin
                next_cycle(ready);
                waited++;
            end
        end
    endtask

    // stall commit and push until fetch closes
    task automatic fill_stalled();
        bit          ready;
        int unsigned n;
        commit_stall_i = 1'b1;
        offer(make_arith());
        fetch_valid_i = 1'b1;
        ready         = 1'b1;
        n             = 0;
        while (ready && n < 8) begin
            next_cycle(ready);
            n++;
            if (ready) offer(make_arith());
        end
        fetch_valid_i = 1'b0;
        assert (n <= 3 && !ready) else begin
            errors++;
            $display("fetch_ready_o stayed high for %0d cycles under stall", n);
        end
    endtask

    initial begin
        void'($urandom(32'h38ef));
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        fetch_valid_i  = 1'b0;
        fetch_entry_i  = '0;
        commit_stall_i = 1'b0;
        cur            = '0;
        errors         = 0;
        commits        = 0;
        next_pc        = 32'h0000_1000;
        rand_mode      = 1'b0;
        test_name      = "reset";
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (16) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;
        next_cycle(rdy);
        check_value("fetch_ready_o", 32'd1, 32'(rdy));
        check_value("commit_valid_o", 32'd0, 32'(commit_valid_o));

        // --------------------
        // random streams
        // --------------------
        rand_mode = 1'b1;
        test_name = "arith";
        repeat (200) send(make_arith());
        drain();
        test_name = "compressed";
        repeat (80) send(make_rvc());
        drain();
        test_name = "illegal_fault";
        repeat (40) begin
            send(make_bad());
            send(make_arith());
        end
        send(i_type(3'b000, rv_slice_pkg::OP_ADD, 5'd0, 5'd1, 12'd5));     // addi x0, x1, 5
        send(r_type(7'h00, 3'b000, rv_slice_pkg::OP_ADD, 5'd2, 5'd0, 5'd0)); // x0 read back
        drain();

        // --------------------
        // directed timing
        // --------------------
        rand_mode      = 1'b0;
        commit_stall_i = 1'b0;
        drain();
        test_name = "latency";
        send(make_arith());
        @(posedge clk_i);
        check_value("commit_valid_o at accept+1", 32'd0, 32'(commit_valid_o));
        @(posedge clk_i);
        check_value("commit_valid_o at accept+2", 32'd1, 32'(commit_valid_o));
        #10;
        drain();

        test_name = "backpressure";
        base      = commits;
        fill_stalled();
        pending = sent_q.size();
        repeat (5) next_cycle(rdy);
        check_value("commits under stall", 32'(base), 32'(commits));
        commit_stall_i = 1'b0;
        drain();
        check_value("commits after release", 32'(base + pending), 32'(commits));

        test_name = "flush";
        base      = commits;
        fill_stalled();
        flush_i = 1'b1;
        void'(sent_q.pop_back());   // the decode register entry is dropped
        pending = sent_q.size();
        next_cycle(rdy);
        offer(make_arith());        // decode register is empty now and only the flush shuts fetch
        fetch_valid_i = 1'b1;
        next_cycle(rdy);
        check_value("fetch_ready_o during flush", 32'd0, 32'(rdy));
        fetch_valid_i  = 1'b0;
        flush_i        = 1'b0;
        commit_stall_i = 1'b0;
        drain();
        repeat (4) next_cycle(rdy); // a flushed entry would commit here
        check_value("commits after flush", 32'(base + pending), 32'(commits));

        $display("errors: %0d, commits: %0d", errors, commits);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/rv_slice_top.sv */
/*
 * RV32 pipeline slice top
 * decode, execute and commit stages in order
 */
`timescale 1ns/1ps
`default_nettype none

module rv_slice_top #(
    parameter bit ENABLE_RVC = 1'b1
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       fetch_valid_i,
    input  rv_slice_pkg::fetch_entry_t fetch_entry_i,
    output logic                       fetch_ready_o,
    input  logic                       commit_stall_i,
    output logic                       commit_valid_o,
    output rv_slice_pkg::commit_t      commit_o
);

    logic                       issue_valid;
    rv_slice_pkg::issue_entry_t issue_entry;
    logic                       issue_ack;
    logic [4:0]                 rs1_addr;
    logic [4:0]                 rs2_addr;
    logic [31:0]                rs1_data;
    logic [31:0]                rs2_data;
    logic                       ex_drain;
    logic                       ex_valid;
    rv_slice_pkg::commit_t      ex_result;

    id_stage #(.ENABLE_RVC(ENABLE_RVC)) i_id_stage (
        .clk_i, .rst_ni, .flush_i, .fetch_valid_i, .fetch_entry_i, .fetch_ready_o,
        .issue_valid_o ( issue_valid ),
        .issue_entry_o ( issue_entry ),
        .issue_ack_i   ( issue_ack   )
    );

    alu_execute i_alu_execute (
        .clk_i, .rst_ni,
        .issue_valid_i ( issue_valid ), .issue_entry_i ( issue_entry ),
        .issue_ack_o   ( issue_ack   ),
        .rs1_addr_o    ( rs1_addr    ), .rs2_addr_o    ( rs2_addr    ),
        .rs1_data_i    ( rs1_data    ), .rs2_data_i    ( rs2_data    ),
        .ex_drain_i    ( ex_drain    ),
        .ex_valid_o    ( ex_valid    ), .ex_result_o   ( ex_result   )
    );

    result_commit i_result_commit (
        .clk_i, .rst_ni, .commit_stall_i, .commit_valid_o, .commit_o,
        .ex_valid_i    ( ex_valid    ), .ex_result_i   ( ex_result   ),
        .ex_drain_o    ( ex_drain    ),
        .rs1_addr_i    ( rs1_addr    ), .rs2_addr_i    ( rs2_addr    ),
        .rs1_data_o    ( rs1_data    ), .rs2_data_o    ( rs2_data    )
    );

endmodule

`default_nettype wire

/* src/result_commit.sv */
/*
 * result and commit stage
 * 32-entry register file, combinational read ports and the commit strobe
 */
`timescale 1ns/1ps
`default_nettype none

module result_commit (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  ex_valid_i,
    input  rv_slice_pkg::commit_t ex_result_i,
    input  logic                  commit_stall_i,
    output logic                  ex_drain_o,
    input  logic [4:0]            rs1_addr_i,
    input  logic [4:0]            rs2_addr_i,
    output logic [31:0]           rs1_data_o,
    output logic [31:0]           rs2_data_o,
    output logic                  commit_valid_o,
    output rv_slice_pkg::commit_t commit_o
);

    logic [31:0] regs_q [rv_slice_pkg::NR_REGS];
    logic        commit_fire;    // retire edge

    assign ex_drain_o     = !commit_stall_i;
    assign commit_fire    = ex_valid_i && !commit_stall_i;
    assign commit_valid_o = ex_valid_i;    // strobe stays up while stalled
    assign commit_o       = ex_result_i;

    // --------------------
    // register file
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned i = 0; i < rv_slice_pkg::NR_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (commit_fire && ex_result_i.we) begin
            regs_q[ex_result_i.rd] <= ex_result_i.data;
        end
    end

    // x0 is hardwired
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? 32'd0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? 32'd0 : regs_q[rs2_addr_i];

    // we is built upstream in execute
    a_no_x0_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (commit_fire && ex_result_i.we) |-> (ex_result_i.rd != 5'd0));

endmodule

`default_nettype wire

/* src/alu_execute.sv */
/*
 * execute stage
 * issue acknowledge, operand read with forwarding, ALU and the result register
 */
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       issue_valid_i,
    input  rv_slice_pkg::issue_entry_t issue_entry_i,
    output logic                       issue_ack_o,
    output logic [4:0]                 rs1_addr_o,
    output logic [4:0]                 rs2_addr_o,
    input  logic [31:0]                rs1_data_i,
    input  logic [31:0]                rs2_data_i,
    input  logic                       ex_drain_i,  // commit takes the result this cycle
    output logic                       ex_valid_o,
    output rv_slice_pkg::commit_t      ex_result_o
);

    logic [31:0]           rs1_val;
    logic [31:0]           rs2_val;
    logic [31:0]           op_b;
    logic [31:0]           alu_res;
    rv_slice_pkg::commit_t ex_d;
    logic                  ex_valid_q;
    rv_slice_pkg::commit_t ex_q;

    assign issue_ack_o = issue_valid_i && (!ex_valid_q || ex_drain_i);

    // --------------------
    // operands
    // --------------------
    assign rs1_addr_o = issue_entry_i.rs1;
    assign rs2_addr_o = issue_entry_i.rs2;

    // register file is written at the end of this cycle, so bypass it
    assign rs1_val = (ex_valid_q && ex_q.we && ex_q.rd == issue_entry_i.rs1) ?
                     ex_q.data : rs1_data_i;
    assign rs2_val = (ex_valid_q && ex_q.we && ex_q.rd == issue_entry_i.rs2) ?
                     ex_q.data : rs2_data_i;
    assign op_b    = issue_entry_i.use_imm ? issue_entry_i.imm : rs2_val;

    // --------------------
    // alu
    // --------------------
    always_comb begin
        alu_res = '0;
        unique case (issue_entry_i.op)
            rv_slice_pkg::OP_ADD: alu_res = rs1_val + op_b;
            rv_slice_pkg::OP_SUB: alu_res = rs1_val - op_b;
            rv_slice_pkg::OP_XOR: alu_res = rs1_val ^ op_b;
            rv_slice_pkg::OP_OR:  alu_res = rs1_val | op_b;
            rv_slice_pkg::OP_AND: alu_res = rs1_val & op_b;
            rv_slice_pkg::OP_SLL: alu_res = rs1_val << op_b[4:0]; // shamt is 5 bits
            rv_slice_pkg::OP_SRL: alu_res = rs1_val >> op_b[4:0];
            rv_slice_pkg::OP_LUI: alu_res = op_b;
            default:              alu_res = '0;
        endcase
    end

    always_comb begin
        ex_d.pc      = issue_entry_i.pc;
        ex_d.rd      = issue_entry_i.rd;
        ex_d.data    = alu_res;
        ex_d.illegal = issue_entry_i.illegal;
        ex_d.fault   = issue_entry_i.fault;
        ex_d.we      = !issue_entry_i.illegal && !issue_entry_i.fault &&
                       (issue_entry_i.rd != 5'd0);
    end

    // --------------------
    // result register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex_valid_q <= 1'b0;
        end else if (issue_ack_o) begin
            ex_valid_q <= 1'b1;
        end else if (ex_drain_i) begin
            ex_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_ack_o) ex_q <= ex_d;
    end

    assign ex_valid_o  = ex_valid_q;
    assign ex_result_o = ex_q;

    // a stalled result is neither overwritten nor lost
    a_hold_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (ex_valid_o && !ex_drain_i) |-> !issue_ack_o ##1 (ex_valid_o && $stable(ex_result_o)));

endmodule

`default_nettype wire

/* src/id_stage.sv */
/*
 * instruction decode stage
 * fetch handshake, optional RVC expansion, decode and the one-deep issue register
 */
`timescale 1ns/1ps
`default_nettype none

module id_stage #(
    parameter bit ENABLE_RVC = 1'b1
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       fetch_valid_i,
    input  rv_slice_pkg::fetch_entry_t fetch_entry_i,
    output logic                       fetch_ready_o,
    output logic                       issue_valid_o,
    output rv_slice_pkg::issue_entry_t issue_entry_o,
    input  logic                       issue_ack_i     // execute sampled the entry
);

    logic [31:0]                instr;          // expanded word
    logic                       rvc_illegal;
    logic                       is_compressed;
    rv_slice_pkg::issue_entry_t decoded;
    logic                       push;
    logic                       valid_q;
    rv_slice_pkg::issue_entry_t entry_q;

    // --------------------
    // decode
    // --------------------
    if (ENABLE_RVC) begin : gen_rvc
        rvc_expander i_rvc_expander (
            .instr_i         ( fetch_entry_i.instruction ),
            .instr_o         ( instr                     ),
            .illegal_o       ( rvc_illegal               ),
            .is_compressed_o ( is_compressed             )
        );
    end else begin : gen_no_rvc
        // a 16-bit word has no 32-bit opcode, so the decoder rejects it
        assign instr         = fetch_entry_i.instruction;
        assign rvc_illegal   = 1'b0;
        assign is_compressed = 1'b0;
    end

    instr_decoder i_instr_decoder (
        .pc_i            ( fetch_entry_i.address ),
        .instr_i         ( instr                 ),
        .is_compressed_i ( is_compressed         ),
        .is_illegal_i    ( rvc_illegal           ),
        .fault_i         ( fetch_entry_i.fault   ),
        .entry_o         ( decoded               )
    );

    // --------------------
    // decode/issue register
    // --------------------
    // room when empty or emptied by the ack this cycle
    assign fetch_ready_o = (!valid_q || issue_ack_i) && !flush_i;
    assign push          = fetch_valid_i && fetch_ready_o;

    assign issue_valid_o = valid_q;
    assign issue_entry_o = entry_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;               // flush wins over ack and push
        end else if (push) begin
            valid_q <= 1'b1;
        end else if (issue_ack_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) entry_q <= decoded;      // payload only
    end

    // a flushed cycle neither takes an entry nor leaves one for execute
    a_flush_drops : assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> !fetch_ready_o ##1 !issue_valid_o);

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
/*
 * instruction decoder
 * combinational decode of a 32-bit RV32I word into an issue entry
 */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic [31:0]                pc_i,
    input  logic [31:0]                instr_i,
    input  logic                       is_compressed_i,
    input  logic                       is_illegal_i,   // from the expander
    input  logic                       fault_i,
    output rv_slice_pkg::issue_entry_t entry_o
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       dec_illegal; // encoding not in the supported set

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        dec_illegal     = 1'b0;
        entry_o         = '0;
        entry_o.pc      = pc_i;
        entry_o.op      = rv_slice_pkg::OP_ADD;
        entry_o.rs1     = instr_i[19:15];
        entry_o.rs2     = instr_i[24:20];
        entry_o.rd      = instr_i[11:7];

        unique case (opcode)
            OPC_LUI: begin
                entry_o.op      = rv_slice_pkg::OP_LUI;
                entry_o.imm     = {instr_i[31:12], 12'b0};
                entry_o.use_imm = 1'b1;
                entry_o.rs1     = '0; // no source registers
                entry_o.rs2     = '0;
            end
            OPC_OP_IMM: begin
                entry_o.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
                entry_o.use_imm = 1'b1;
                entry_o.rs2     = '0; // field belongs to the immediate
                unique case (funct3)
                    3'b000:  entry_o.op = rv_slice_pkg::OP_ADD; // addi
                    3'b100:  entry_o.op = rv_slice_pkg::OP_XOR; // xori
                    3'b110:  entry_o.op = rv_slice_pkg::OP_OR;  // ori
                    3'b111:  entry_o.op = rv_slice_pkg::OP_AND; // andi
                    default: dec_illegal = 1'b1;                // slti, shifts-by-imm, ...
                endcase
            end
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    unique case (funct3)
                        3'b000:  entry_o.op = rv_slice_pkg::OP_ADD;
                        3'b001:  entry_o.op = rv_slice_pkg::OP_SLL;
                        3'b100:  entry_o.op = rv_slice_pkg::OP_XOR;
                        3'b101:  entry_o.op = rv_slice_pkg::OP_SRL;
                        3'b110:  entry_o.op = rv_slice_pkg::OP_OR;
                        3'b111:  entry_o.op = rv_slice_pkg::OP_AND;
                        default: dec_illegal = 1'b1; // slt, sltu
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    entry_o.op = rv_slice_pkg::OP_SUB;
                end else begin
                    dec_illegal = 1'b1; // sra and the M extension land here
                end
            end
            default: dec_illegal = 1'b1;
        endcase

        entry_o.illegal       = dec_illegal | is_illegal_i;
        entry_o.fault         = fault_i;
        entry_o.is_compressed = is_compressed_i;

        // nothing that will not execute may name a destination
        if (entry_o.illegal || fault_i) begin
            entry_o.rd = '0;
        end
    end

endmodule

`default_nettype wire

/* src/rvc_expander.sv */
/*
 * compressed instruction expander
 * rebuilds C.LI, C.ADDI, C.MV and C.ADD as 32-bit ADDI/ADD, flags the rest
 */
`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
    input  logic [31:0] instr_i,
    output logic [31:0] instr_o,
    output logic        illegal_o,
    output logic        is_compressed_o
);

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [11:0] c_imm;   // 6-bit immediate sign extended to 12
    logic [4:0]  c_rd;    // rd/rs1 field of CI and CR formats
    logic [4:0]  c_rs2;

    assign c_imm = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};
    assign c_rd  = instr_i[11:7];
    assign c_rs2 = instr_i[6:2];

    assign is_compressed_o = (instr_i[1:0] != 2'b11);

    always_comb begin
        instr_o   = instr_i; // 32-bit words pass untouched
        illegal_o = 1'b0;
        if (is_compressed_o) begin
            instr_o   = '0;
            illegal_o = 1'b1;   // cleared below for supported encodings
            unique case ({instr_i[1:0], instr_i[15:13]})
                5'b01_000: begin // C.ADDI -> addi rd, rd, imm
                    instr_o   = {c_imm, c_rd, 3'b000, c_rd, OPC_OP_IMM};
                    illegal_o = 1'b0;
                end
                5'b01_010: begin // C.LI -> addi rd, x0, imm
                    instr_o   = {c_imm, 5'd0, 3'b000, c_rd, OPC_OP_IMM};
                    illegal_o = 1'b0;
                end
                5'b10_100: begin
                    // rs2 == 0 would be C.JR/C.JALR/C.EBREAK, not supported
                    if (c_rs2 != 5'd0) begin
                        if (instr_i[12]) begin
                            // C.ADD -> add rd, rd, rs2
                            instr_o = {7'b0, c_rs2, c_rd, 3'b000, c_rd, OPC_OP};
                        end else begin
                            // C.MV -> add rd, x0, rs2
                            instr_o = {7'b0, c_rs2, 5'd0, 3'b000, c_rd, OPC_OP};
                        end
                        illegal_o = 1'b0;
                    end
                end
                default: ; // every other compressed encoding stays illegal
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/rv_slice_pkg.sv */
/*
 * RV32 integer slice package
 * operation codes and the structs passed between fetch, decode, execute and commit
 */
`default_nettype none

package rv_slice_pkg;

    localparam int unsigned NR_REGS = 32; // architectural integer registers

    // --------------------
    // operation codes
    // --------------------
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_OR,
        OP_AND,
        OP_SLL,
        OP_SRL,
        OP_LUI  // result is the immediate itself
    } alu_op_e;

    // --------------------
    // pipeline payloads
    // --------------------
    // what the fetch unit hands over
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] instruction; // compressed ones sit in [15:0]
        logic        fault;       // fetch went wrong, do not execute
    } fetch_entry_t;

    // decoded instruction, held in the decode/issue register
    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     op;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;            // zero for illegal or faulting entries
        logic [31:0] imm;           // sign extended I or U immediate
        logic        use_imm;       // operand b is imm instead of rs2
        logic        illegal;
        logic        fault;
        logic        is_compressed;
    } issue_entry_t;

    // execute result, also the commit report
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        we;      // real register write, never x0
        logic        illegal;
        logic        fault;
    } commit_t;

endpackage

`default_nettype wire
